//--- graph_pkg.sv
`default_nettype none

package graph_pkg;

	////////////////////
	// Unit bank

	// Number of vertex units in the bank
	localparam int NUM_UNITS = 4;

	// Unit id carried with each read command and response
	localparam int UNIT_W = 2;

	// Active unit count, 0 up to NUM_UNITS
	localparam int ACTIVE_W = $clog2(NUM_UNITS + 1);

	////////////////////
	// Job and data widths

	// Vertex id, also the width of the vertex total
	localparam int VERTEX_W = 16;

	// Edge address
	localparam int ADDR_W = 32;

	// Degree and per-unit edge count
	localparam int DEGREE_W = 8;

	// Edge total over all units
	localparam int EDGE_COUNT_W = 24;

	// Edge data returned by memory
	localparam int DATA_W = 32;

	// Running sum of edge data
	localparam int SUM_W = 40;

	// Packed job word in the job buffer
	localparam int JOB_W = VERTEX_W + ADDR_W + DEGREE_W;

	// Read command in the burst queue, address then unit id
	localparam int CMD_W = ADDR_W + UNIT_W;

	////////////////////
	// Buffering and flow control

	// Job buffer depth, also the job credits the host starts with
	localparam int JOB_BUF_DEPTH = 8;

	localparam int CMD_QUEUE_DEPTH = 4;
	localparam int BURST_DEPTH = 16;

	// Read credits granted by memory after reset
	localparam int MEM_CREDITS = 8;
	localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);

	// Vertex unit FSM
	typedef enum logic [1:0] {
		UNIT_IDLE,
		UNIT_ISSUE,
		UNIT_DRAIN
	} unit_state_t;

endpackage

`default_nettype wire

//--- graph_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module graph_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]   mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [COUNT_W-1:0] count;

	// Storage array
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead head entry
	assign data_out    = mem[rd_ptr];
	assign full        = (count == COUNT_W'(DEPTH));
	assign almost_full = (count >= COUNT_W'(DEPTH - 1));
	assign empty       = (count == '0);

	// Callers throttle on the flags so these catch a broken handshake upstream
	no_overflow: assert property (@(posedge clock) disable iff (!rstn) !(push && full))
		else $error("push into a full FIFO");
	no_underflow: assert property (@(posedge clock) disable iff (!rstn) !(pop && empty))
		else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
	parameter int N = 4
) (
	input  logic         clock,
	input  logic         rstn,
	input  logic [N-1:0] request,
	output logic [N-1:0] grant
);

	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [IDX_W-1:0] last_idx;
	logic [IDX_W-1:0] grant_idx;
	logic             found;

	// Search starts one past the last winner and wraps around
	always_comb begin
		int idx;
		grant     = '0;
		grant_idx = last_idx;
		found     = 1'b0;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last_idx) + k) % N;
			if (!found && request[idx]) begin
				grant[idx] = 1'b1;
				grant_idx  = IDX_W'(idx);
				found      = 1'b1;
			end
		end
	end

	// Start so that requester 0 has first priority
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_idx <= IDX_W'(N - 1);
		end else if (found) begin
			last_idx <= grant_idx;
		end
	end

	grant_onehot: assert property (@(posedge clock) disable iff (!rstn) $onehot0(grant))
		else $error("arbiter granted more than one requester");

endmodule

`default_nettype wire

//--- vertex_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_unit #(
	parameter logic [graph_pkg::UNIT_W-1:0] UNIT_ID = '0
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enable,
	input  logic                           job_grant,
	input  logic [graph_pkg::VERTEX_W-1:0] job_vertex,
	input  logic [graph_pkg::ADDR_W-1:0]   job_edge_base,
	input  logic [graph_pkg::DEGREE_W-1:0] job_degree,
	input  logic                           queue_almost_full,
	input  logic                           rsp_valid,
	input  logic [graph_pkg::DATA_W-1:0]   rsp_data,
	output logic                           idle,
	output logic                           cmd_push,
	output logic [graph_pkg::ADDR_W-1:0]   cmd_addr,
	output logic                           done,
	output logic [graph_pkg::DEGREE_W-1:0] done_edges,
	output logic [graph_pkg::SUM_W-1:0]    done_sum
);

	import graph_pkg::*;

	unit_state_t         state;
	logic [VERTEX_W-1:0] cur_vertex;
	logic [ADDR_W-1:0]   cur_base;
	logic [DEGREE_W-1:0] cur_degree;
	logic [DEGREE_W-1:0] issue_count;
	logic [DEGREE_W-1:0] rsp_count;
	logic [SUM_W-1:0]    acc_sum;
	logic                drain_done;

	assign idle       = enable && (state == UNIT_IDLE);
	assign cmd_push   = (state == UNIT_ISSUE) && !queue_almost_full;
	assign cmd_addr   = cur_base + ADDR_W'(issue_count);
	assign drain_done = (state == UNIT_DRAIN) && (rsp_count == cur_degree);

	////////////////////
	// Control FSM
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= UNIT_IDLE;
			issue_count <= '0;
			rsp_count   <= '0;
			done        <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				UNIT_IDLE: begin
					if (job_grant) begin
						issue_count <= '0;
						rsp_count   <= '0;
						// Degree zero has nothing to read
						state <= (job_degree == '0) ? UNIT_DRAIN : UNIT_ISSUE;
					end
				end
				UNIT_ISSUE: begin
					if (cmd_push) begin
						issue_count <= issue_count + 1'b1;
						if (issue_count == cur_degree - 1'b1) begin
							state <= UNIT_DRAIN;
						end
					end
				end
				UNIT_DRAIN: begin
					if (drain_done) begin
						done  <= 1'b1;
						state <= UNIT_IDLE;
					end
				end
				default: state <= UNIT_IDLE;
			endcase
			if (rsp_valid) begin
				rsp_count <= rsp_count + 1'b1;
			end
		end
	end

	////////////////////
	// Job fields and edge data sum
	always_ff @(posedge clock) begin
		if (state == UNIT_IDLE && job_grant) begin
			cur_vertex <= job_vertex;
			cur_base   <= job_edge_base;
			cur_degree <= job_degree;
			acc_sum    <= '0;
		end else if (rsp_valid) begin
			acc_sum <= acc_sum + SUM_W'(rsp_data);
		end
		if (drain_done) begin
			done_edges <= cur_degree;
			done_sum   <= acc_sum;
		end
	end

	// Router must only steer responses to a unit that has reads out
	no_rsp_when_idle: assert property (@(posedge clock) disable iff (!rstn)
		!(rsp_valid && state == UNIT_IDLE))
		else $error("unit %0d got a response while idle", UNIT_ID);

	rsp_within_degree: assert property (@(posedge clock) disable iff (!rstn)
		(rsp_valid && state != UNIT_IDLE) |-> (rsp_count < cur_degree))
		else $error("unit %0d vertex %0d got more responses than edges", UNIT_ID, cur_vertex);

endmodule

`default_nettype wire

//--- read_command_merge.sv
`timescale 1ns/1ps
`default_nettype none

module read_command_merge (
	input  logic                                                 clock,
	input  logic                                                 rstn,
	input  logic [graph_pkg::NUM_UNITS-1:0]                      unit_push,
	input  logic [graph_pkg::NUM_UNITS-1:0][graph_pkg::ADDR_W-1:0] unit_addr,
	input  logic                                                 mem_credit,
	output logic [graph_pkg::NUM_UNITS-1:0]                      queue_almost_full,
	output logic                                                 cmd_valid,
	output logic [graph_pkg::ADDR_W-1:0]                         cmd_addr,
	output logic [graph_pkg::UNIT_W-1:0]                         cmd_unit
);

	import graph_pkg::*;

	logic [NUM_UNITS-1:0]             queue_empty;
	logic [NUM_UNITS-1:0][ADDR_W-1:0] queue_addr;
	logic [NUM_UNITS-1:0]             merge_request;
	logic [NUM_UNITS-1:0]             merge_grant;
	logic [UNIT_W-1:0]                grant_unit;
	logic                             merge_valid;
	logic [CMD_W-1:0]                 merge_cmd;
	logic [CMD_W-1:0]                 burst_out;
	logic                             burst_almost_full;
	logic                             burst_empty;
	logic                             burst_pop;
	logic [CREDIT_W-1:0]              credit_count;

	////////////////////
	// Per-unit command queues
	for (genvar i = 0; i < NUM_UNITS; i++) begin : gen_queue
		graph_fifo #(
			.WIDTH(ADDR_W),
			.DEPTH(CMD_QUEUE_DEPTH)
		) cmd_queue (
			.clock      (clock),
			.rstn       (rstn),
			.push       (unit_push[i]),
			.data_in    (unit_addr[i]),
			.pop        (merge_grant[i]),
			.data_out   (queue_addr[i]),
			.full       (),
			.almost_full(queue_almost_full[i]),
			.empty      (queue_empty[i])
		);

		// Hold off while the burst queue is close to full
		assign merge_request[i] = !queue_empty[i] && !burst_almost_full;
	end

	rr_arbiter #(
		.N(NUM_UNITS)
	) merge_arbiter (
		.clock  (clock),
		.rstn   (rstn),
		.request(merge_request),
		.grant  (merge_grant)
	);

	always_comb begin
		grant_unit = '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (merge_grant[i]) begin
				grant_unit = UNIT_W'(i);
			end
		end
	end

	// Merge stage register
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			merge_valid <= 1'b0;
		end else begin
			merge_valid <= |merge_grant;
		end
	end

	always_ff @(posedge clock) begin
		merge_cmd <= {queue_addr[grant_unit], grant_unit};
	end

	////////////////////
	// Burst queue toward memory
	graph_fifo #(
		.WIDTH(CMD_W),
		.DEPTH(BURST_DEPTH)
	) burst_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (merge_valid),
		.data_in    (merge_cmd),
		.pop        (burst_pop),
		.data_out   (burst_out),
		.full       (),
		.almost_full(burst_almost_full),
		.empty      (burst_empty)
	);

	assign burst_pop = !burst_empty && (credit_count != '0);

	// One credit per command, one back per mem_credit pulse
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credit_count <= CREDIT_W'(MEM_CREDITS);
			cmd_valid    <= 1'b0;
		end else begin
			credit_count <= credit_count - CREDIT_W'(burst_pop) + CREDIT_W'(mem_credit);
			cmd_valid    <= burst_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (burst_pop) begin
			{cmd_addr, cmd_unit} <= burst_out;
		end
	end

	// Memory returning more credits than it handed out
	credit_bound: assert property (@(posedge clock) disable iff (!rstn)
		credit_count <= CREDIT_W'(MEM_CREDITS))
		else $error("read credit count above MEM_CREDITS");

endmodule

`default_nettype wire

//--- response_router.sv
`timescale 1ns/1ps
`default_nettype none

module response_router (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic [graph_pkg::NUM_UNITS-1:0] unit_enable,
	input  logic                            rsp_valid,
	input  logic [graph_pkg::UNIT_W-1:0]    rsp_unit,
	input  logic [graph_pkg::DATA_W-1:0]    rsp_data,
	output logic [graph_pkg::NUM_UNITS-1:0] unit_rsp_valid,
	output logic [graph_pkg::DATA_W-1:0]    unit_rsp_data
);

	import graph_pkg::*;

	logic [NUM_UNITS-1:0] route_valid;

	// Only the addressed unit sees the valid, and only when enabled
	always_comb begin
		for (int i = 0; i < NUM_UNITS; i++) begin
			route_valid[i] = rsp_valid && unit_enable[i] && (rsp_unit == UNIT_W'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			unit_rsp_valid <= '0;
		end else begin
			unit_rsp_valid <= route_valid;
		end
	end

	// Data is shared by all units
	always_ff @(posedge clock) begin
		unit_rsp_data <= rsp_data;
	end

endmodule

`default_nettype wire

//--- graph_control.sv
`timescale 1ns/1ps
`default_nettype none

module graph_control (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic [graph_pkg::ACTIVE_W-1:0]     active_units,
	input  logic                               job_valid,
	input  logic [graph_pkg::VERTEX_W-1:0]     job_vertex,
	input  logic [graph_pkg::ADDR_W-1:0]       job_edge_base,
	input  logic [graph_pkg::DEGREE_W-1:0]     job_degree,
	input  logic                               mem_credit,
	input  logic                               rsp_valid,
	input  logic [graph_pkg::UNIT_W-1:0]       rsp_unit,
	input  logic [graph_pkg::DATA_W-1:0]       rsp_data,
	output logic                               job_credit,
	output logic                               cmd_valid,
	output logic [graph_pkg::ADDR_W-1:0]       cmd_addr,
	output logic [graph_pkg::UNIT_W-1:0]       cmd_unit,
	output logic [graph_pkg::VERTEX_W-1:0]     vertex_total,
	output logic [graph_pkg::EDGE_COUNT_W-1:0] edge_total,
	output logic [graph_pkg::SUM_W-1:0]        data_sum
);

	import graph_pkg::*;

	logic [NUM_UNITS-1:0]               enable_mask;
	logic [JOB_W-1:0]                   job_head;
	logic [VERTEX_W-1:0]                head_vertex;
	logic [ADDR_W-1:0]                  head_edge_base;
	logic [DEGREE_W-1:0]                head_degree;
	logic                               job_empty;
	logic                               job_pop;
	logic [NUM_UNITS-1:0]               dispatch_request;
	logic [NUM_UNITS-1:0]               dispatch_grant;
	logic [NUM_UNITS-1:0]               unit_idle;
	logic [NUM_UNITS-1:0]               unit_cmd_push;
	logic [NUM_UNITS-1:0][ADDR_W-1:0]   unit_cmd_addr;
	logic [NUM_UNITS-1:0]               queue_almost_full;
	logic [NUM_UNITS-1:0]               unit_rsp_valid;
	logic [DATA_W-1:0]                  unit_rsp_data;
	logic [NUM_UNITS-1:0]               unit_done;
	logic [NUM_UNITS-1:0][DEGREE_W-1:0] unit_done_edges;
	logic [NUM_UNITS-1:0][SUM_W-1:0]    unit_done_sum;
	logic [VERTEX_W-1:0]                vertex_add;
	logic [EDGE_COUNT_W-1:0]            edge_add;
	logic [SUM_W-1:0]                   sum_add;

	// Units below the requested count are enabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enable_mask <= '0;
		end else begin
			for (int i = 0; i < NUM_UNITS; i++) begin
				enable_mask[i] <= (ACTIVE_W'(i) < active_units);
			end
		end
	end

	////////////////////
	// Job buffer and dispatch
	graph_fifo #(
		.WIDTH(JOB_W),
		.DEPTH(JOB_BUF_DEPTH)
	) job_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_valid),
		.data_in    ({job_vertex, job_edge_base, job_degree}),
		.pop        (job_pop),
		.data_out   (job_head),
		.full       (),
		.almost_full(),
		.empty      (job_empty)
	);

	assign {head_vertex, head_edge_base, head_degree} = job_head;
	assign dispatch_request = unit_idle & {NUM_UNITS{!job_empty}};
	assign job_pop = |dispatch_grant;

	rr_arbiter #(
		.N(NUM_UNITS)
	) dispatch_arbiter (
		.clock  (clock),
		.rstn   (rstn),
		.request(dispatch_request),
		.grant  (dispatch_grant)
	);

	// Credit goes back to the host the cycle after each pop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_credit <= 1'b0;
		end else begin
			job_credit <= job_pop;
		end
	end

	for (genvar i = 0; i < NUM_UNITS; i++) begin : gen_unit
		vertex_unit #(
			.UNIT_ID(UNIT_W'(i))
		) unit (
			.clock            (clock),
			.rstn             (rstn),
			.enable           (enable_mask[i]),
			.job_grant        (dispatch_grant[i]),
			.job_vertex       (head_vertex),
			.job_edge_base    (head_edge_base),
			.job_degree       (head_degree),
			.queue_almost_full(queue_almost_full[i]),
			.rsp_valid        (unit_rsp_valid[i]),
			.rsp_data         (unit_rsp_data),
			.idle             (unit_idle[i]),
			.cmd_push         (unit_cmd_push[i]),
			.cmd_addr         (unit_cmd_addr[i]),
			.done             (unit_done[i]),
			.done_edges       (unit_done_edges[i]),
			.done_sum         (unit_done_sum[i])
		);
	end

	read_command_merge merge (
		.clock            (clock),
		.rstn             (rstn),
		.unit_push        (unit_cmd_push),
		.unit_addr        (unit_cmd_addr),
		.mem_credit       (mem_credit),
		.queue_almost_full(queue_almost_full),
		.cmd_valid        (cmd_valid),
		.cmd_addr         (cmd_addr),
		.cmd_unit         (cmd_unit)
	);

	response_router router (
		.clock         (clock),
		.rstn          (rstn),
		.unit_enable   (enable_mask),
		.rsp_valid     (rsp_valid),
		.rsp_unit      (rsp_unit),
		.rsp_data      (rsp_data),
		.unit_rsp_valid(unit_rsp_valid),
		.unit_rsp_data (unit_rsp_data)
	);

	////////////////////
	// Completion totals
	always_comb begin
		vertex_add = '0;
		edge_add   = '0;
		sum_add    = '0;
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (unit_done[i]) begin
				vertex_add = vertex_add + 1'b1;
				edge_add   = edge_add + EDGE_COUNT_W'(unit_done_edges[i]);
				sum_add    = sum_add + unit_done_sum[i];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_total <= '0;
			edge_total   <= '0;
			data_sum     <= '0;
		end else begin
			vertex_total <= vertex_total + vertex_add;
			edge_total   <= edge_total + edge_add;
			data_sum     <= data_sum + sum_add;
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic rstn
);

	// Free running clock, 8 ns period by default
	initial begin
		clock = 1'b0;
		forever begin
			#HALF_PERIOD clock = ~clock;
		end
	end

	// Reset held low for the first few rising edges
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_graph_control.sv
`timescale 1ns/1ps
`default_nettype none

module tb_graph_control;

	import graph_pkg::*;

	localparam int RANDOM_JOBS = 30;
	localparam int SINGLE_JOBS = 12;
	localparam int STALL_JOBS = 12;
	localparam int MAX_DEGREE = 6;
	localparam int MAX_DELAY = 6;
	localparam int STALL_CYCLES = 200;
	localparam int MAX_EDGES = (RANDOM_JOBS + SINGLE_JOBS + STALL_JOBS) * MAX_DEGREE;
	localparam int TIMEOUT_CYCLES = 40 * MAX_EDGES + 2000;

	logic                    clock;
	logic                    rstn;
	logic [ACTIVE_W-1:0]     active_units;
	logic                    job_valid;
	logic [VERTEX_W-1:0]     job_vertex;
	logic [ADDR_W-1:0]       job_edge_base;
	logic [DEGREE_W-1:0]     job_degree;
	logic                    mem_credit;
	logic                    rsp_valid;
	logic [UNIT_W-1:0]       rsp_unit;
	logic [DATA_W-1:0]       rsp_data;
	logic                    job_credit;
	logic                    cmd_valid;
	logic [ADDR_W-1:0]       cmd_addr;
	logic [UNIT_W-1:0]       cmd_unit;
	logic [VERTEX_W-1:0]     vertex_total;
	logic [EDGE_COUNT_W-1:0] edge_total;
	logic [SUM_W-1:0]        data_sum;

	int seed = 42;
	int host_credits;
	int cycle_count;
	bit hold_credit = 1'b0;
	bit single_unit = 1'b0;

	// Every job sent for the reference model
	logic [ADDR_W-1:0]   all_base[$];
	logic [DEGREE_W-1:0] all_degree[$];

	// Jobs waiting for a host credit
	logic [VERTEX_W-1:0] pend_vertex[$];
	logic [ADDR_W-1:0]   pend_base[$];
	logic [DEGREE_W-1:0] pend_degree[$];

	tb_clock_gen clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	graph_control DUT (
		.clock        (clock),
		.rstn         (rstn),
		.active_units (active_units),
		.job_valid    (job_valid),
		.job_vertex   (job_vertex),
		.job_edge_base(job_edge_base),
		.job_degree   (job_degree),
		.mem_credit   (mem_credit),
		.rsp_valid    (rsp_valid),
		.rsp_unit     (rsp_unit),
		.rsp_data     (rsp_data),
		.job_credit   (job_credit),
		.cmd_valid    (cmd_valid),
		.cmd_addr     (cmd_addr),
		.cmd_unit     (cmd_unit),
		.vertex_total (vertex_total),
		.edge_total   (edge_total),
		.data_sum     (data_sum)
	);

	////////////////////
	// Reference model

	// Memory contents as a pure function of the address
	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
		return DATA_W'(addr * 3 + 7);
	endfunction

	function automatic void expected_totals(
		output logic [VERTEX_W-1:0]     vertices,
		output logic [EDGE_COUNT_W-1:0] edges,
		output logic [SUM_W-1:0]        sum
	);
		logic [ADDR_W-1:0] addr;
		vertices = VERTEX_W'(all_degree.size());
		edges = '0;
		sum = '0;
		foreach (all_degree[j]) begin
			edges = edges + EDGE_COUNT_W'(all_degree[j]);
			for (int k = 0; k < int'(all_degree[j]); k++) begin
				addr = all_base[j] + ADDR_W'(k);
				sum = sum + SUM_W'(mem_word(addr));
			end
		end
	endfunction

	////////////////////
	// Checks

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_unit(input string name, input logic [UNIT_W-1:0] expected,
		input logic [UNIT_W-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_vertex(input string name, input logic [VERTEX_W-1:0] expected,
		input logic [VERTEX_W-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_edges(input string name, input logic [EDGE_COUNT_W-1:0] expected,
		input logic [EDGE_COUNT_W-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_sum(input string name, input logic [SUM_W-1:0] expected,
		input logic [SUM_W-1:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_credits(input string name, input int expected, input int actual);
		if (actual != expected) begin
			report_failure($sformatf("** Error %s: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic check_totals(input string name);
		logic [VERTEX_W-1:0]     exp_vertices;
		logic [EDGE_COUNT_W-1:0] exp_edges;
		logic [SUM_W-1:0]        exp_sum;
		expected_totals(exp_vertices, exp_edges, exp_sum);
		check_vertex({name, " vertex_total"}, exp_vertices, vertex_total);
		check_edges({name, " edge_total"}, exp_edges, edge_total);
		check_sum({name, " data_sum"}, exp_sum, data_sum);
	endtask

	////////////////////
	// Stimulus helpers called at the falling edge

	task automatic queue_jobs(input int count);
		logic [ADDR_W-1:0]   base;
		logic [DEGREE_W-1:0] degree;
		for (int j = 0; j < count; j++) begin
			base = $random(seed);
			degree = DEGREE_W'($unsigned($random(seed)) % (MAX_DEGREE + 1));
			pend_vertex.push_back(VERTEX_W'(all_degree.size()));
			pend_base.push_back(base);
			pend_degree.push_back(degree);
			all_base.push_back(base);
			all_degree.push_back(degree);
		end
	endtask

	// Completion is marked by the vertex total
	task automatic wait_for_jobs;
		while (vertex_total < VERTEX_W'(all_degree.size())) begin
			@(negedge clock);
		end
	endtask

	task automatic set_active(input int count);
		@(posedge clock);
		active_units <= ACTIVE_W'(count);
		repeat (2) @(posedge clock);
		@(negedge clock);
	endtask

	////////////////////
	// Job source with host credits
	initial begin : job_source
		job_valid = 1'b0;
		job_vertex = '0;
		job_edge_base = '0;
		job_degree = '0;
		host_credits = JOB_BUF_DEPTH;
		forever begin
			@(posedge clock);
			if (job_credit) begin
				host_credits++;
			end
			if (pend_degree.size() > 0 && host_credits > 0) begin
				job_valid <= 1'b1;
				job_vertex <= pend_vertex.pop_front();
				job_edge_base <= pend_base.pop_front();
				job_degree <= pend_degree.pop_front();
				host_credits--;
			end else begin
				job_valid <= 1'b0;
			end
			if (host_credits > JOB_BUF_DEPTH) begin
				report_failure("More job credits returned than jobs sent, job buffer can overflow");
			end
		end
	end

	////////////////////
	// Out of order memory model with random latency
	initial begin : memory_model
		logic [ADDR_W-1:0] rq_addr[$];
		logic [UNIT_W-1:0] rq_unit[$];
		int                rq_ready[$];
		int                mem_cycle;
		int                cmds_seen;
		int                credits_given;
		int                hold_cmds;
		int                pick;
		rsp_valid = 1'b0;
		rsp_unit = '0;
		rsp_data = '0;
		mem_credit = 1'b0;
		mem_cycle = 0;
		cmds_seen = 0;
		credits_given = 0;
		hold_cmds = 0;
		forever begin
			@(posedge clock);
			mem_cycle++;
			if (cmd_valid) begin
				cmds_seen++;
				if (hold_credit) begin
					hold_cmds++;
				end
				if (single_unit) begin
					check_unit("single unit cmd_unit", '0, cmd_unit);
				end
				rq_addr.push_back(cmd_addr);
				rq_unit.push_back(cmd_unit);
				rq_ready.push_back(mem_cycle + 1 + $unsigned($random(seed)) % MAX_DELAY);
			end
			if (cmds_seen - credits_given > MEM_CREDITS || hold_cmds > MEM_CREDITS) begin
				report_failure("More read commands outstanding than memory credits granted");
			end
			pick = -1;
			if (!hold_credit) begin
				for (int i = 0; i < rq_ready.size(); i++) begin
					if (pick < 0 && rq_ready[i] <= mem_cycle) begin
						pick = i;
					end
				end
			end
			if (pick >= 0) begin
				rsp_valid <= 1'b1;
				rsp_unit <= rq_unit[pick];
				rsp_data <= mem_word(rq_addr[pick]);
				mem_credit <= 1'b1;
				credits_given++;
				rq_addr.delete(pick);
				rq_unit.delete(pick);
				rq_ready.delete(pick);
			end else begin
				rsp_valid <= 1'b0;
				mem_credit <= 1'b0;
			end
		end
	end

	// Run limit from the longest possible edge count
	initial begin : watchdog
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES) begin
				report_failure($sformatf("Timeout after %0d cycles with %0d of %0d jobs done",
					cycle_count, vertex_total, all_degree.size()));
			end
		end
	end

	////////////////////
	// Test sequence
	initial begin
		active_units = ACTIVE_W'(NUM_UNITS);
		@(posedge rstn);
		@(negedge clock);

		// Outputs straight after reset
		check_bit("reset cmd_valid", 1'b0, cmd_valid);
		check_bit("reset job_credit", 1'b0, job_credit);
		check_vertex("reset vertex_total", '0, vertex_total);
		check_edges("reset edge_total", '0, edge_total);
		check_sum("reset data_sum", '0, data_sum);

		// All units active
		queue_jobs(RANDOM_JOBS);
		wait_for_jobs();
		check_totals("random jobs");

		// Single unit
		set_active(1);
		single_unit = 1'b1;
		queue_jobs(SINGLE_JOBS);
		wait_for_jobs();
		check_totals("single unit");
		single_unit = 1'b0;
		set_active(NUM_UNITS);

		// Memory credits withheld, then restored
		hold_credit = 1'b1;
		queue_jobs(STALL_JOBS);
		repeat (STALL_CYCLES) @(negedge clock);
		hold_credit = 1'b0;
		wait_for_jobs();
		check_totals("credit stall");

		// Every job credit back at the host
		check_credits("host job credits", JOB_BUF_DEPTH, host_credits);

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
graph_pkg.sv
graph_fifo.sv
rr_arbiter.sv
vertex_unit.sv
read_command_merge.sv
response_router.sv
graph_control.sv
tb_clock_gen.sv
tb_graph_control.sv
